/* run_sim.sh */
#!/bin/sh
# Build and run the icache testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f src.f --top-module icache_tb
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

output=$(./obj_dir/Vicache_tb)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if echo "$output" | grep -q "Test completed successfully"; then
	exit 0
fi
exit 1

/* src.f */
+incdir+verilog
verilog/icache_types_pkg.sv
verilog/icache_state_pkg.sv
verilog/icache_av_slave.sv
verilog/icache_way.sv
verilog/icache_refill.sv
verilog/icache_top.sv
test/icache_assert.sv
test/icache_tb.sv

/* test/icache_assert.sv */
`timescale 1ns/1ps

module icache_assert (
	input logic                          clk,
	input logic                          reset_n,
	input logic                          read,
	input logic                          readdatavalid,
	input logic                          waitrequest,
	input icache_types_pkg::byte_addr_t  master_address,
	input logic                          master_read,
	input logic                          master_beginbursttransfer,
	input icache_types_pkg::burst_cnt_t  master_burstcount,
	input logic                          master_waitrequest
);

	logic pending;

	// Tracks the one read the slave has accepted but not yet answered
	always_ff @(posedge clk)
	begin
		if (!reset_n)
			pending <= 1'b0;
		else if (read && !waitrequest)
			pending <= 1'b1;
		else if (readdatavalid)
			pending <= 1'b0;
	end

	master_stable: assert property (@(posedge clk) disable iff (!reset_n)
		master_read && master_waitrequest |=>
			master_read && $stable(master_address) && $stable(master_burstcount))
		else $error("master request changed while master_waitrequest was high");

	// Begin marks exactly the first cycle of each burst request
	begin_with_read: assert property (@(posedge clk) disable iff (!reset_n)
		master_beginbursttransfer == (master_read && !$past(master_read)))
		else $error("beginbursttransfer not in the first cycle of the burst request");

	rdv_outstanding: assert property (@(posedge clk) disable iff (!reset_n)
		readdatavalid |-> pending && !$past(read && !waitrequest))
		else $error("readdatavalid with no read outstanding or right after acceptance");

	quiet_in_reset: assert property (@(posedge clk)
		!reset_n && $past(!reset_n) |-> !master_read && !readdatavalid && waitrequest)
		else $error("outputs active during reset");

endmodule

/* test/icache_tb.sv */
`timescale 1ns/1ps
`include "icache_config.svh"

module icache_tb;

	localparam int MISS_CYCLES = 16;
	localparam int NUM_READS = 40;
	localparam int CYCLE_LIMIT = 20 * MISS_CYCLES * NUM_READS;
	localparam int RAND_READS = 24;

	logic clk;
	logic reset_n;
	icache_types_pkg::word_addr_t address;
	logic read;
	icache_types_pkg::word_t readdata;
	logic readdatavalid;
	logic waitrequest;
	icache_types_pkg::byte_addr_t master_address;
	logic master_read;
	logic master_beginbursttransfer;
	icache_types_pkg::burst_cnt_t master_burstcount;
	logic [`SDRAM_WIDTH-1:0] master_readdata;
	logic master_readdatavalid;
	logic master_waitrequest;

	logic [31:0] lfsr;
	logic backpressure;
	int cycles;
	int bursts_seen;

	// Reference copy of the tag state
	icache_types_pkg::tag_t model_tag [`ICACHE_SETS][`ICACHE_WAYS];
	logic model_valid [`ICACHE_SETS][`ICACHE_WAYS];
	icache_types_pkg::way_sel_t model_rr [`ICACHE_SETS];

	icache_types_pkg::word_addr_t rand_addr [RAND_READS];

	icache_top uut (.*);

	bind icache_top icache_assert u_assert (
		.clk                        (clk),
		.reset_n                    (reset_n),
		.read                       (read),
		.readdatavalid              (readdatavalid),
		.waitrequest                (waitrequest),
		.master_address             (master_address),
		.master_read                (master_read),
		.master_beginbursttransfer  (master_beginbursttransfer),
		.master_burstcount          (master_burstcount),
		.master_waitrequest         (master_waitrequest)
	);

	initial
	begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
	endfunction

	function logic [7:0] take_bits(input int n);
		logic [7:0] r;
		r = '0;
		for (int i = 0; i < n; i++)
		begin
			lfsr = lfsr_next(lfsr);
			r = {r[6:0], lfsr[0]};
		end
		return r;
	endfunction

	function automatic icache_types_pkg::word_t mem_word(input icache_types_pkg::byte_addr_t a);
		return a ^ 32'h5a5a0000;
	endfunction

	task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] act);
		assert (exp === act)
		else
		begin
			$display("FAIL %s expected %h actual %h", name, exp, act);
			$display("Test failed");
			$fatal(1);
		end
	endtask

	task automatic model_clear();
		for (int s = 0; s < `ICACHE_SETS; s++)
		begin
			model_rr[s] = '0;
			for (int w = 0; w < `ICACHE_WAYS; w++)
				model_valid[s][w] = 1'b0;
		end
	endtask

	// Looks the address up and allocates the round-robin victim on a miss
	function automatic logic model_access(input icache_types_pkg::word_addr_t a);
		icache_types_pkg::index_t idx;
		icache_types_pkg::tag_t tag;
		idx = a[`ICACHE_OFFSET_BITS +: `ICACHE_INDEX_BITS];
		tag = a[29:`ICACHE_OFFSET_BITS + `ICACHE_INDEX_BITS];
		for (int w = 0; w < `ICACHE_WAYS; w++)
			if (model_valid[idx][w] && model_tag[idx][w] == tag)
				return 1'b1;
		model_tag[idx][model_rr[idx]] = tag;
		model_valid[idx][model_rr[idx]] = 1'b1;
		model_rr[idx] = icache_types_pkg::way_sel_t'(model_rr[idx] + 1'b1);
		return 1'b0;
	endfunction

	task automatic do_read(input string name, input icache_types_pkg::word_addr_t a);
		logic exp_hit;
		logic stalled;
		int bursts_before;
		int lat;
		icache_types_pkg::word_t data;
		exp_hit = model_access(a);
		bursts_before = bursts_seen;
		address = a;
		read = 1'b1;
		// The read is taken at the first edge after a cycle with waitrequest low
		stalled = 1'b1;
		while (stalled)
		begin
			@(negedge clk);
			stalled = waitrequest;
			@(posedge clk);
		end
		#1;
		read = 1'b0;
		lat = 0;
		@(negedge clk);
		while (!readdatavalid)
		begin
			lat++;
			@(negedge clk);
		end
		data = readdata;
		@(posedge clk);
		#1;
		check_value({name, " data"}, mem_word({a, 2'b00}), data);
		check_value({name, " bursts"}, exp_hit ? 32'd0 : 32'd1, 32'(bursts_seen - bursts_before));
		if (exp_hit)
			check_value({name, " hit latency"}, 32'd2, 32'(lat));
	endtask

	// SDRAM burst model
	initial
	begin
		int beat;
		logic streaming;
		logic granted;
		logic [7:0] wait_bits;
		icache_types_pkg::byte_addr_t base;
		beat = 0;
		streaming = 1'b0;
		granted = 1'b0;
		base = '0;
		forever
		begin
			// A grant seen mid-cycle starts the burst at the next edge
			@(negedge clk);
			granted = reset_n && master_read && !master_waitrequest;
			if (granted)
			begin
				check_value("burstcount", `ICACHE_LINE_WORDS, 32'(master_burstcount));
				check_value("burst alignment", 32'd0, {28'd0, master_address[3:0]});
				base = master_address;
			end
			@(posedge clk);
			if (granted)
			begin
				beat = 0;
				streaming = 1'b1;
				bursts_seen++;
			end
			#1;
			if (!reset_n)
				streaming = 1'b0;
			master_readdatavalid = streaming;
			master_readdata = mem_word(base + 32'(beat * 4));
			if (streaming)
			begin
				beat++;
				if (beat == `ICACHE_LINE_WORDS)
					streaming = 1'b0;
			end
			if (backpressure)
			begin
				wait_bits = take_bits(1);
				master_waitrequest = wait_bits[0];
			end
			else
				master_waitrequest = 1'b0;
		end
	end

	always @(posedge clk)
	begin
		cycles <= cycles + 1;
		if (cycles > CYCLE_LIMIT)
		begin
			$display("Timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
			$display("Test failed");
			$fatal(1);
		end
	end

	initial
	begin
		logic [7:0] tag_bits;
		logic [7:0] low_bits;
		lfsr = 32'ha06a;
		cycles = 0;
		bursts_seen = 0;
		backpressure = 1'b0;
		reset_n = 1'b0;
		address = '0;
		read = 1'b0;
		master_readdata = '0;
		master_readdatavalid = 1'b0;
		master_waitrequest = 1'b0;
		model_clear();
		repeat (5) @(posedge clk);
		#1;
		reset_n = 1'b1;

		// Lines A, B and C share set 0
		do_read("cold_miss", 30'h41);
		do_read("hit_w0", 30'h40);
		do_read("hit_w2", 30'h42);
		do_read("hit_w3", 30'h43);
		do_read("way1_miss", 30'h82);
		do_read("way0_hit", 30'h40);
		do_read("way1_hit", 30'h81);
		do_read("evict_miss", 30'hc0);
		do_read("evicted_miss", 30'h43);
		do_read("after_evict_hit", 30'hc3);
		do_read("second_evict", 30'h80);

		for (int i = 0; i < RAND_READS; i++)
		begin
			tag_bits = take_bits(2);
			low_bits = take_bits(4);
			rand_addr[i] = {22'd0, tag_bits[1:0], 2'b00, low_bits[3:0]};
		end
		@(negedge clk);
		backpressure = 1'b1;
		@(posedge clk);
		#1;
		for (int i = 0; i < RAND_READS; i++)
			do_read("backpressure", rand_addr[i]);
		@(negedge clk);
		backpressure = 1'b0;

		@(posedge clk);
		#1;
		reset_n = 1'b0;
		repeat (5) @(posedge clk);
		#1;
		reset_n = 1'b1;
		model_clear();
		do_read("reset_miss_a", 30'h40);
		do_read("reset_miss_c", 30'hc1);
		do_read("reset_hit_a", 30'h42);

		$display("Test completed successfully");
		$finish;
	end

endmodule

/* verilog/icache_av_slave.sv */
`timescale 1ns/1ps
`include "icache_config.svh"

module icache_av_slave (
	input  logic                          clk,
	input  logic                          reset_n,

	input  icache_types_pkg::word_addr_t  address,
	input  logic                          read,
	output icache_types_pkg::word_t       readdata,
	output logic                          readdatavalid,
	output logic                          waitrequest,

	output logic                          req_valid,
	output icache_types_pkg::index_t      req_index,
	output icache_types_pkg::tag_t        req_tag,
	output icache_types_pkg::offset_t     req_offset,

	input  logic                          resp_valid,
	input  icache_types_pkg::word_t       resp_data
);

	localparam int INDEX_LO = `ICACHE_OFFSET_BITS;
	localparam int TAG_LO = `ICACHE_OFFSET_BITS + `ICACHE_INDEX_BITS;

	logic outstanding;
	logic accept;

	assign accept = read & ~waitrequest;

	// Only one read in flight, so the port stalls until its answer shows up
	assign waitrequest = ~reset_n | (outstanding & ~resp_valid);
	assign readdatavalid = resp_valid & outstanding;
	assign readdata = resp_data;

	always_ff @(posedge clk)
	begin
		if (!reset_n)
		begin
			outstanding <= 1'b0;
			req_valid <= 1'b0;
		end
		else
		begin
			req_valid <= accept;
			if (accept)
				outstanding <= 1'b1;
			else if (readdatavalid)
				outstanding <= 1'b0;
		end
	end

	// Request fields hold until the next accepted read
	always_ff @(posedge clk)
	begin
		if (accept)
		begin
			req_offset <= address[INDEX_LO-1:0];
			req_index <= address[TAG_LO-1:INDEX_LO];
			req_tag <= address[$bits(icache_types_pkg::word_addr_t)-1:TAG_LO];
		end
	end

endmodule

/* verilog/icache_config.svh */
`ifndef ICACHE_CONFIG_SVH
`define ICACHE_CONFIG_SVH

// Cache geometry
`define ICACHE_WAYS 2
`define ICACHE_SETS 16
`define ICACHE_LINE_WORDS 4

// Word address split, log2 of sets and line words
`define ICACHE_INDEX_BITS 4
`define ICACHE_OFFSET_BITS 2

// Master side
`define SDRAM_WIDTH 32
`define IBURSTCOUNTWIDTH 3

`endif

/* verilog/icache_refill.sv */
`timescale 1ns/1ps
`include "icache_config.svh"

module icache_refill (
	input  logic                                             clk,
	input  logic                                             reset_n,

	input  logic                                             req_valid,
	input  icache_types_pkg::index_t                         req_index,
	input  icache_types_pkg::tag_t                           req_tag,
	input  icache_types_pkg::offset_t                        req_offset,

	input  logic [`ICACHE_WAYS-1:0]                          way_valid,
	input  icache_types_pkg::tag_t [`ICACHE_WAYS-1:0]        way_tag,
	input  icache_types_pkg::word_t [`ICACHE_WAYS-1:0]       way_word,

	output icache_types_pkg::way_sel_t                       fill_way,
	output logic                                             fill_en,
	output logic                                             fill_tag_en,
	output icache_types_pkg::index_t                         fill_index,
	output icache_types_pkg::offset_t                        fill_offset,
	output icache_types_pkg::tag_t                           fill_tag,
	output icache_types_pkg::word_t                          fill_data,

	output logic                                             resp_valid,
	output icache_types_pkg::word_t                          resp_data,

	output icache_types_pkg::byte_addr_t                     master_address,
	output logic                                             master_read,
	output logic                                             master_beginbursttransfer,
	output icache_types_pkg::burst_cnt_t                     master_burstcount,
	input  logic [`SDRAM_WIDTH-1:0]                          master_readdata,
	input  logic                                             master_readdatavalid,
	input  logic                                             master_waitrequest
);

	icache_state_pkg::refill_state_t state;
	icache_types_pkg::way_sel_t rr_ptr [`ICACHE_SETS];
	icache_types_pkg::way_sel_t victim;
	icache_types_pkg::offset_t beat;
	logic burst_first;
	logic hit_any;
	icache_types_pkg::word_t hit_word;
	logic master_accept;
	logic last_beat;

	always_comb
	begin
		hit_any = 1'b0;
		hit_word = way_word[0];
		for (int w = 0; w < `ICACHE_WAYS; w++)
		begin
			if (way_valid[w] && way_tag[w] == req_tag)
			begin
				hit_any = 1'b1;
				hit_word = way_word[w];
			end
		end
	end

	// Burst always starts at word 0 of the line
	assign master_address = {req_tag, req_index, {`ICACHE_OFFSET_BITS{1'b0}}, 2'b00};
	assign master_burstcount = icache_types_pkg::burst_cnt_t'(`ICACHE_LINE_WORDS);
	assign master_read = (state == icache_state_pkg::BURST_REQ);
	assign master_beginbursttransfer = master_read & burst_first;
	assign master_accept = master_read & ~master_waitrequest;

	assign last_beat = (beat == icache_types_pkg::offset_t'(`ICACHE_LINE_WORDS - 1));
	assign fill_en = (state == icache_state_pkg::BURST_DATA) & master_readdatavalid;
	assign fill_tag_en = fill_en & last_beat;
	assign fill_way = victim;
	assign fill_index = req_index;
	assign fill_offset = beat;
	assign fill_tag = req_tag;
	assign fill_data = master_readdata;

	assign resp_valid = (state == icache_state_pkg::RESPOND);

	always_ff @(posedge clk)
	begin
		if (!reset_n)
		begin
			state <= icache_state_pkg::IDLE;
			burst_first <= 1'b0;
			beat <= '0;
			victim <= '0;
			for (int s = 0; s < `ICACHE_SETS; s++)
				rr_ptr[s] <= '0;
		end
		else
		begin
			case (state)
			icache_state_pkg::IDLE:
				if (req_valid)
					state <= icache_state_pkg::LOOKUP;
			icache_state_pkg::LOOKUP:
				if (hit_any)
					state <= icache_state_pkg::RESPOND;
				else
				begin
					victim <= rr_ptr[req_index];
					rr_ptr[req_index] <= icache_types_pkg::way_sel_t'(rr_ptr[req_index] + 1'b1);
					burst_first <= 1'b1;
					state <= icache_state_pkg::BURST_REQ;
				end
			icache_state_pkg::BURST_REQ:
			begin
				burst_first <= 1'b0;
				if (master_accept)
				begin
					beat <= '0;
					state <= icache_state_pkg::BURST_DATA;
				end
			end
			icache_state_pkg::BURST_DATA:
				if (master_readdatavalid)
				begin
					beat <= beat + 1'b1;
					if (last_beat)
						state <= icache_state_pkg::RESPOND;
				end
			default:
				state <= icache_state_pkg::IDLE;
			endcase
		end
	end

	// Requested word comes either from the hit way or as it streams past in the burst
	always_ff @(posedge clk)
	begin
		if (state == icache_state_pkg::LOOKUP && hit_any)
			resp_data <= hit_word;
		else if (fill_en && beat == req_offset)
			resp_data <= master_readdata;
	end

endmodule

/* verilog/icache_state_pkg.sv */
package icache_state_pkg;

	// Refill controller states
	typedef enum logic [2:0] {
		IDLE,
		LOOKUP,
		BURST_REQ,
		BURST_DATA,
		RESPOND
	} refill_state_t;

endpackage

/* verilog/icache_top.sv */
`timescale 1ns/1ps
`include "icache_config.svh"

module icache_top (
	input  logic                          clk,
	input  logic                          reset_n,

	input  icache_types_pkg::word_addr_t  address,
	input  logic                          read,
	output icache_types_pkg::word_t       readdata,
	output logic                          readdatavalid,
	output logic                          waitrequest,

	output icache_types_pkg::byte_addr_t  master_address,
	output logic                          master_read,
	output logic                          master_beginbursttransfer,
	output icache_types_pkg::burst_cnt_t  master_burstcount,
	input  logic [`SDRAM_WIDTH-1:0]       master_readdata,
	input  logic                          master_readdatavalid,
	input  logic                          master_waitrequest
);

	logic req_valid;
	icache_types_pkg::index_t req_index;
	icache_types_pkg::tag_t req_tag;
	icache_types_pkg::offset_t req_offset;
	logic resp_valid;
	icache_types_pkg::word_t resp_data;

	logic [`ICACHE_WAYS-1:0] way_valid;
	icache_types_pkg::tag_t [`ICACHE_WAYS-1:0] way_tag;
	icache_types_pkg::word_t [`ICACHE_WAYS-1:0] way_word;

	icache_types_pkg::way_sel_t fill_way;
	logic fill_en;
	logic fill_tag_en;
	icache_types_pkg::index_t fill_index;
	icache_types_pkg::offset_t fill_offset;
	icache_types_pkg::tag_t fill_tag;
	icache_types_pkg::word_t fill_data;

	icache_av_slave u_slave (
		.clk            (clk),
		.reset_n        (reset_n),
		.address        (address),
		.read           (read),
		.readdata       (readdata),
		.readdatavalid  (readdatavalid),
		.waitrequest    (waitrequest),
		.req_valid      (req_valid),
		.req_index      (req_index),
		.req_tag        (req_tag),
		.req_offset     (req_offset),
		.resp_valid     (resp_valid),
		.resp_data      (resp_data)
	);

	genvar g;
	generate
		for (g = 0; g < `ICACHE_WAYS; g++)
		begin : g_way
			logic way_fill_en;
			logic way_fill_tag_en;

			// Only the victim way sees the fill strobes
			assign way_fill_en = fill_en & (fill_way == icache_types_pkg::way_sel_t'(g));
			assign way_fill_tag_en = fill_tag_en & (fill_way == icache_types_pkg::way_sel_t'(g));

			icache_way u_way (
				.clk            (clk),
				.reset_n        (reset_n),
				.lookup_en      (req_valid),
				.lookup_index   (req_index),
				.lookup_offset  (req_offset),
				.hit_valid      (way_valid[g]),
				.hit_tag        (way_tag[g]),
				.hit_word       (way_word[g]),
				.fill_en        (way_fill_en),
				.fill_tag_en    (way_fill_tag_en),
				.fill_index     (fill_index),
				.fill_offset    (fill_offset),
				.fill_tag       (fill_tag),
				.fill_data      (fill_data)
			);
		end
	endgenerate

	icache_refill u_refill (
		.clk                        (clk),
		.reset_n                    (reset_n),
		.req_valid                  (req_valid),
		.req_index                  (req_index),
		.req_tag                    (req_tag),
		.req_offset                 (req_offset),
		.way_valid                  (way_valid),
		.way_tag                    (way_tag),
		.way_word                   (way_word),
		.fill_way                   (fill_way),
		.fill_en                    (fill_en),
		.fill_tag_en                (fill_tag_en),
		.fill_index                 (fill_index),
		.fill_offset                (fill_offset),
		.fill_tag                   (fill_tag),
		.fill_data                  (fill_data),
		.resp_valid                 (resp_valid),
		.resp_data                  (resp_data),
		.master_address             (master_address),
		.master_read                (master_read),
		.master_beginbursttransfer  (master_beginbursttransfer),
		.master_burstcount          (master_burstcount),
		.master_readdata            (master_readdata),
		.master_readdatavalid       (master_readdatavalid),
		.master_waitrequest         (master_waitrequest)
	);

endmodule

/* verilog/icache_types_pkg.sv */
`include "icache_config.svh"

package icache_types_pkg;

	typedef logic [29:0] word_addr_t;
	typedef logic [31:0] byte_addr_t;
	typedef logic [31:0] word_t;

	// Tag is whatever is left of the word address above index and offset
	typedef logic [29-`ICACHE_INDEX_BITS-`ICACHE_OFFSET_BITS:0] tag_t;
	typedef logic [`ICACHE_INDEX_BITS-1:0] index_t;
	typedef logic [`ICACHE_OFFSET_BITS-1:0] offset_t;

	typedef logic [$clog2(`ICACHE_WAYS)-1:0] way_sel_t;
	typedef logic [`IBURSTCOUNTWIDTH-1:0] burst_cnt_t;

endpackage

/* verilog/icache_way.sv */
`timescale 1ns/1ps
`include "icache_config.svh"

module icache_way (
	input  logic                       clk,
	input  logic                       reset_n,

	input  logic                       lookup_en,
	input  icache_types_pkg::index_t   lookup_index,
	input  icache_types_pkg::offset_t  lookup_offset,
	output logic                       hit_valid,
	output icache_types_pkg::tag_t     hit_tag,
	output icache_types_pkg::word_t    hit_word,

	input  logic                       fill_en,
	input  logic                       fill_tag_en,
	input  icache_types_pkg::index_t   fill_index,
	input  icache_types_pkg::offset_t  fill_offset,
	input  icache_types_pkg::tag_t     fill_tag,
	input  icache_types_pkg::word_t    fill_data
);

	logic [`ICACHE_SETS-1:0] valid;
	icache_types_pkg::tag_t tag_mem [`ICACHE_SETS];
	icache_types_pkg::word_t data_mem [`ICACHE_SETS][`ICACHE_LINE_WORDS];

	// Valid bits and the registered hit flag
	always_ff @(posedge clk)
	begin
		if (!reset_n)
		begin
			valid <= '0;
			hit_valid <= 1'b0;
		end
		else
		begin
			if (fill_tag_en)
				valid[fill_index] <= 1'b1;
			if (lookup_en)
				hit_valid <= valid[lookup_index];
		end
	end

	always_ff @(posedge clk)
	begin
		if (fill_en)
			data_mem[fill_index][fill_offset] <= fill_data;
		if (fill_tag_en)
			tag_mem[fill_index] <= fill_tag;
		if (lookup_en)
		begin
			hit_tag <= tag_mem[lookup_index];
			hit_word <= data_mem[lookup_index][lookup_offset];
		end
	end

endmodule
